//--- verilog/exec_pkg.sv
package exec_pkg;

   // Opcode of one execute operation
   typedef logic [3:0] alu_op_t;

   localparam alu_op_t OP_ADD  = 4'd0;
   localparam alu_op_t OP_SUB  = 4'd1;
   localparam alu_op_t OP_AND  = 4'd2;
   localparam alu_op_t OP_OR   = 4'd3;
   localparam alu_op_t OP_XOR  = 4'd4;
   localparam alu_op_t OP_SHL  = 4'd5;
   localparam alu_op_t OP_SHR  = 4'd6;
   localparam alu_op_t OP_SAR  = 4'd7;
   localparam alu_op_t OP_MINU = 4'd8;
   localparam alu_op_t OP_MAXU = 4'd9;

   // Highest legal opcode, 10 to 15 are reserved
   localparam alu_op_t OP_LAST = OP_MAXU;

   // Status flags, same meaning as the x86 EFLAGS bits
   typedef logic [5:0] flags_t;

   localparam int FLAG_CF = 0;
   localparam int FLAG_PF = 1;
   localparam int FLAG_AF = 2;
   localparam int FLAG_ZF = 3;
   localparam int FLAG_SF = 4;
   localparam int FLAG_OF = 5;

   // Shift kind between the top level and the shifter
   typedef logic [1:0] shift_kind_t;

   localparam shift_kind_t SHIFT_LEFT  = 2'd0;
   localparam shift_kind_t SHIFT_RIGHT = 2'd1;
   localparam shift_kind_t SHIFT_ARITH = 2'd2;

endpackage

//--- verilog/cla_adder.sv
module cla_adder #(
   parameter int DATA_WIDTH = 32
) (
   input  logic [DATA_WIDTH-1:0] a,
   input  logic [DATA_WIDTH-1:0] b,
   input  logic                  sub,
   output logic [DATA_WIDTH-1:0] sum,
   output logic                  carry,
   output logic                  aux_carry,
   output logic                  overflow
);

   localparam int NUM_GROUPS = DATA_WIDTH / 4;

   logic [DATA_WIDTH-1:0] b_eff;
   logic [DATA_WIDTH-1:0] p;
   logic [DATA_WIDTH-1:0] g;
   logic [DATA_WIDTH:0]   c;
   logic [NUM_GROUPS-1:0] grp_p;
   logic [NUM_GROUPS-1:0] grp_g;
   logic [NUM_GROUPS:0]   grp_c;
   logic                  cin;

   // Subtract is a + ~b + 1
   assign b_eff = sub ? ~b : b;
   assign cin   = sub;

   assign p = a ^ b_eff;
   assign g = a & b_eff;

   // Nibble group propagate and generate
   always_comb begin
      for (int i = 0; i < NUM_GROUPS; i++) begin
         grp_p[i] = &p[4*i +: 4];
         grp_g[i] = g[4*i+3]
                  | (p[4*i+3] & g[4*i+2])
                  | (p[4*i+3] & p[4*i+2] & g[4*i+1])
                  | (p[4*i+3] & p[4*i+2] & p[4*i+1] & g[4*i]);
      end
   end

   // Group carries, each one expanded all the way down to cin
   always_comb begin
      logic prod;
      prod     = 1'b1;
      grp_c[0] = cin;
      for (int i = 0; i < NUM_GROUPS; i++) begin
         prod       = 1'b1;
         grp_c[i+1] = 1'b0;
         for (int j = i; j >= 0; j--) begin
            grp_c[i+1] = grp_c[i+1] | (prod & grp_g[j]);
            prod       = prod & grp_p[j];
         end
         grp_c[i+1] = grp_c[i+1] | (prod & cin);
      end
   end

   // Bit carries inside each group start from the group carry
   always_comb begin
      for (int i = 0; i < NUM_GROUPS; i++) begin
         c[4*i] = grp_c[i];
         for (int k = 0; k < 3; k++) begin
            c[4*i+k+1] = g[4*i+k] | (p[4*i+k] & c[4*i+k]);
         end
      end
      c[DATA_WIDTH] = grp_c[NUM_GROUPS];
   end

   assign sum = p ^ c[DATA_WIDTH-1:0];

   // Carry out of bit 3 is the nibble carry, inverted into a borrow on subtract
   assign aux_carry = c[4] ^ sub;
   assign carry     = c[DATA_WIDTH] ^ sub;

   // Same operand signs but a different result sign
   assign overflow = (a[DATA_WIDTH-1] == b_eff[DATA_WIDTH-1]) &&
                     (sum[DATA_WIDTH-1] != a[DATA_WIDTH-1]);

   a_sum_matches: assert final (sum == (sub ? a - b : a + b))
      else $error("cla_adder sum differs from the arithmetic result");

endmodule

//--- verilog/barrel_shifter.sv
module barrel_shifter #(
   parameter int DATA_WIDTH = 32
) (
   input  logic [DATA_WIDTH-1:0]         data,
   input  logic [$clog2(DATA_WIDTH)-1:0] count,
   input  exec_pkg::shift_kind_t         kind,
   output logic [DATA_WIDTH-1:0]         shifted,
   output logic                          shift_out
);

   import exec_pkg::*;

   localparam int CNT_W = $clog2(DATA_WIDTH);

   // Stage s holds the data after the count bits below s are applied
   logic [CNT_W:0][DATA_WIDTH-1:0] stage;
   logic [CNT_W:0]                 last_bit;

   always_comb begin
      int sh;
      stage[0]    = data;
      last_bit[0] = 1'b0;
      for (int s = 0; s < CNT_W; s++) begin
         sh = 1 << s;
         if (count[s]) begin
            case (kind)
               SHIFT_RIGHT: begin
                  stage[s+1]    = stage[s] >> sh;
                  last_bit[s+1] = stage[s][sh-1];
               end
               SHIFT_ARITH: begin
                  // Fill with the sign bit
                  stage[s+1]    = $unsigned($signed(stage[s]) >>> sh);
                  last_bit[s+1] = stage[s][sh-1];
               end
               default: begin
                  stage[s+1]    = stage[s] << sh;
                  last_bit[s+1] = stage[s][DATA_WIDTH-sh];
               end
            endcase
         end else begin
            stage[s+1]    = stage[s];
            last_bit[s+1] = last_bit[s];
         end
      end
   end

   assign shifted   = stage[CNT_W];
   assign shift_out = last_bit[CNT_W];

   a_no_shift_out: assert final (count != '0 || !shift_out)
      else $error("barrel_shifter reports a shifted-out bit for a zero count");

endmodule

//--- verilog/mag_comp.sv
module mag_comp #(
   parameter int DATA_WIDTH = 32
) (
   input  logic [DATA_WIDTH-1:0] a,
   input  logic [DATA_WIDTH-1:0] b,
   output logic                  a_gt_b,
   output logic                  a_eq_b
);

   localparam int NUM_BYTES = DATA_WIDTH / 8;

   logic [NUM_BYTES-1:0] byte_gt;
   logic [NUM_BYTES-1:0] byte_eq;

   // Per-byte compare
   always_comb begin
      for (int i = 0; i < NUM_BYTES; i++) begin
         byte_gt[i] = a[8*i +: 8] > b[8*i +: 8];
         byte_eq[i] = a[8*i +: 8] == b[8*i +: 8];
      end
   end

   // Walk down from the top byte
   // a lower byte only decides when all higher bytes match
   always_comb begin
      logic higher_eq;
      logic gt;
      higher_eq = 1'b1;
      gt        = 1'b0;
      for (int i = NUM_BYTES - 1; i >= 0; i--) begin
         gt        = gt | (higher_eq & byte_gt[i]);
         higher_eq = higher_eq & byte_eq[i];
      end
      a_gt_b = gt;
      a_eq_b = higher_eq;
   end

   a_exclusive: assert final (!(a_gt_b && a_eq_b))
      else $error("mag_comp reports greater and equal at once");

endmodule

//--- verilog/flag_gen.sv
module flag_gen #(
   parameter int DATA_WIDTH = 32
) (
   input  exec_pkg::alu_op_t     op,
   input  logic [DATA_WIDTH-1:0] result,
   input  logic                  carry,
   input  logic                  aux_carry,
   input  logic                  overflow,
   input  logic                  shift_out,
   input  logic                  shift_zero,
   output exec_pkg::flags_t      flags
);

   import exec_pkg::*;

   logic no_arith_flags;

   // Logic ops and min/max clear CF, AF and OF
   assign no_arith_flags = (op == OP_AND)  || (op == OP_OR)   || (op == OP_XOR) ||
                           (op == OP_MINU) || (op == OP_MAXU);

   always_comb begin
      flags = '0;

      // Result flags for every operation
      flags[FLAG_ZF] = ~|result;
      flags[FLAG_SF] = result[DATA_WIDTH-1];
      flags[FLAG_PF] = ~^result[7:0];

      case (op)
         OP_ADD, OP_SUB: begin
            // Adder already turns carries into borrows on SUB
            flags[FLAG_CF] = carry;
            flags[FLAG_AF] = aux_carry;
            flags[FLAG_OF] = overflow;
         end
         OP_SHL, OP_SHR, OP_SAR: begin
            flags[FLAG_CF] = shift_zero ? 1'b0 : shift_out;
         end
         default: begin
         end
      endcase
   end

   a_quiet_flags: assert final (!no_arith_flags ||
                                (!flags[FLAG_CF] && !flags[FLAG_AF] && !flags[FLAG_OF]))
      else $error("flag_gen sets CF, AF or OF for a logic or min/max op");

endmodule

//--- verilog/exec_unit.sv
module exec_unit #(
   parameter int DATA_WIDTH = 32
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  in_valid,
   input  exec_pkg::alu_op_t     op,
   input  logic [DATA_WIDTH-1:0] a,
   input  logic [DATA_WIDTH-1:0] b,
   output logic                  out_valid,
   output logic [DATA_WIDTH-1:0] result,
   output exec_pkg::flags_t      flags
);

   import exec_pkg::*;

   localparam int SHIFT_W = $clog2(DATA_WIDTH);

   // Stage 1 operand registers
   logic                  valid_q;
   alu_op_t               op_q;
   logic [DATA_WIDTH-1:0] a_q;
   logic [DATA_WIDTH-1:0] b_q;

   // Datapath side outputs
   logic                  sub;
   logic [DATA_WIDTH-1:0] sum;
   logic                  carry;
   logic                  aux_carry;
   logic                  overflow;
   shift_kind_t           kind;
   logic [SHIFT_W-1:0]    count;
   logic [DATA_WIDTH-1:0] shifted;
   logic                  shift_out;
   logic                  shift_zero;
   logic                  a_gt_b;
   logic                  a_eq_b;
   logic [DATA_WIDTH-1:0] sel_result;
   flags_t                sel_flags;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         op_q <= op;
         a_q  <= a;
         b_q  <= b;
      end
   end

   // MINU/MAXU run the adder as a subtract too
   assign sub = (op_q == OP_SUB) || (op_q == OP_MINU) || (op_q == OP_MAXU);

   assign kind = (op_q == OP_SHR) ? SHIFT_RIGHT :
                 (op_q == OP_SAR) ? SHIFT_ARITH : SHIFT_LEFT;

   // Count is b modulo the width
   assign count      = b_q[SHIFT_W-1:0];
   assign shift_zero = (count == '0);

   cla_adder #(.DATA_WIDTH(DATA_WIDTH)) u_adder (
      .a         (a_q),
      .b         (b_q),
      .sub       (sub),
      .sum       (sum),
      .carry     (carry),
      .aux_carry (aux_carry),
      .overflow  (overflow)
   );

   barrel_shifter #(.DATA_WIDTH(DATA_WIDTH)) u_shifter (
      .data      (a_q),
      .count     (count),
      .kind      (kind),
      .shifted   (shifted),
      .shift_out (shift_out)
   );

   mag_comp #(.DATA_WIDTH(DATA_WIDTH)) u_comp (
      .a      (a_q),
      .b      (b_q),
      .a_gt_b (a_gt_b),
      .a_eq_b (a_eq_b)
   );

   always_comb begin
      case (op_q)
         OP_ADD, OP_SUB:         sel_result = sum;
         OP_AND:                 sel_result = a_q & b_q;
         OP_OR:                  sel_result = a_q | b_q;
         OP_XOR:                 sel_result = a_q ^ b_q;
         OP_SHL, OP_SHR, OP_SAR: sel_result = shifted;
         OP_MINU:                sel_result = a_gt_b ? b_q : a_q;
         OP_MAXU:                sel_result = a_gt_b ? a_q : b_q;
         default:                sel_result = '0;
      endcase
   end

   flag_gen #(.DATA_WIDTH(DATA_WIDTH)) u_flags (
      .op         (op_q),
      .result     (sel_result),
      .carry      (carry),
      .aux_carry  (aux_carry),
      .overflow   (overflow),
      .shift_out  (shift_out),
      .shift_zero (shift_zero),
      .flags      (sel_flags)
   );

   // Stage 2 output registers
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= valid_q;
      end
   end

   always_ff @(posedge clk) begin
      if (valid_q) begin
         result <= sel_result;
         flags  <= sel_flags;
      end
   end

   a_legal_op: assert property (@(posedge clk) disable iff (!rst_n)
      in_valid |-> op <= OP_LAST)
      else $error("illegal opcode accepted");

   // Adder and comparator agree on equal operands
   a_sub_vs_comp: assert property (@(posedge clk) disable iff (!rst_n)
      valid_q && op_q == OP_SUB |-> (sum == '0) == a_eq_b)
      else $error("subtract result and comparator disagree on equality");

endmodule

//--- verification/exec_unit_ref.svh
`ifndef EXEC_UNIT_REF_SVH
`define EXEC_UNIT_REF_SVH

// Expected {flags, result} for one operation, following the x86 flag rules
function automatic logic [DATA_WIDTH+5:0] reference_result(
   input alu_op_t               o,
   input logic [DATA_WIDTH-1:0] x,
   input logic [DATA_WIDTH-1:0] y
);
   logic [DATA_WIDTH:0]   wide;
   logic [DATA_WIDTH-1:0] res;
   flags_t                f;
   int                    cnt;
   int                    msb;
   msb = DATA_WIDTH - 1;
   cnt = y % DATA_WIDTH;
   f   = '0;
   res = '0;
   case (o)
      OP_ADD: begin
         wide       = {1'b0, x} + {1'b0, y};
         res        = wide[DATA_WIDTH-1:0];
         f[FLAG_CF] = wide[DATA_WIDTH];
         f[FLAG_AF] = ({1'b0, x[3:0]} + {1'b0, y[3:0]}) > 5'd15;
         f[FLAG_OF] = (x[msb] == y[msb]) && (res[msb] != x[msb]);
      end
      OP_SUB: begin
         res        = x - y;
         // Borrows
         f[FLAG_CF] = x < y;
         f[FLAG_AF] = x[3:0] < y[3:0];
         f[FLAG_OF] = (x[msb] != y[msb]) && (res[msb] != x[msb]);
      end
      OP_AND: res = x & y;
      OP_OR:  res = x | y;
      OP_XOR: res = x ^ y;
      OP_SHL: begin
         res = x << cnt;
         if (cnt != 0) f[FLAG_CF] = x[DATA_WIDTH-cnt];
      end
      OP_SHR: begin
         res = x >> cnt;
         if (cnt != 0) f[FLAG_CF] = x[cnt-1];
      end
      OP_SAR: begin
         res = $signed(x) >>> cnt;
         if (cnt != 0) f[FLAG_CF] = x[cnt-1];
      end
      OP_MINU: res = (x < y) ? x : y;
      OP_MAXU: res = (x > y) ? x : y;
      default: res = '0;
   endcase
   f[FLAG_ZF] = (res == '0);
   f[FLAG_SF] = res[msb];
   f[FLAG_PF] = ~^res[7:0];
   return {f, res};
endfunction

`endif

//--- verification/exec_unit_tb.sv
module exec_unit_tb;

   import exec_pkg::*;

   localparam int DATA_WIDTH  = 32;
   localparam int DRAIN_LIMIT = 50;

   logic                  clk;
   logic                  rst_n;
   logic                  in_valid;
   alu_op_t               op;
   logic [DATA_WIDTH-1:0] a;
   logic [DATA_WIDTH-1:0] b;
   logic                  out_valid;
   logic [DATA_WIDTH-1:0] result;
   flags_t                flags;

   // Expected {flags, result}, test name and output cycle of each operation
   logic [DATA_WIDTH+5:0] exp_q[$];
   string                 name_q[$];
   int                    due_q[$];

   integer seed    = 32'hf0a0a878;
   int     errors  = 0;
   int     checked = 0;
   int     cyc     = 0;

   `include "exec_unit_ref.svh"

   exec_unit #(.DATA_WIDTH(DATA_WIDTH)) uut (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .op        (op),
      .a         (a),
      .b         (b),
      .out_valid (out_valid),
      .result    (result),
      .flags     (flags)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   function automatic alu_op_t random_op();
      return alu_op_t'($unsigned($random(seed)) % 10);
   endfunction

   // Called just after a rising edge so the DUT samples at the next one
   task automatic send_op(input alu_op_t o, input logic [DATA_WIDTH-1:0] x,
                          input logic [DATA_WIDTH-1:0] y, input string name);
      in_valid = 1'b1;
      op       = o;
      a        = x;
      b        = y;
      exp_q.push_back(reference_result(o, x, y));
      name_q.push_back(name);
      due_q.push_back(cyc + 2);
      @(posedge clk);
      #1;
   endtask

   task automatic idle_cycles(input int n);
      in_valid = 1'b0;
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   // Outputs are stable at the falling edge
   always @(negedge clk) begin : compare
      logic [DATA_WIDTH+5:0] exp_val;
      string                 name;
      int                    due;
      if (out_valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            $display("Unexpected output: out_valid high with nothing outstanding, cycle %0d",
                     cyc);
            errors++;
         end else begin
            exp_val = exp_q.pop_front();
            name    = name_q.pop_front();
            due     = due_q.pop_front();
            checked++;
            if ({flags, result} !== exp_val) begin
               $display("** Error %s: expected result %h flags %b, actual result %h flags %b",
                        name, exp_val[DATA_WIDTH-1:0], exp_val[DATA_WIDTH+5:DATA_WIDTH],
                        result, flags);
               errors++;
            end
            if (cyc != due) begin
               $display("Operation %s came out at cycle %0d instead of cycle %0d",
                        name, cyc, due);
               errors++;
            end
         end
      end else if (out_valid !== 1'b0) begin
         $display("out_valid is unknown at cycle %0d", cyc);
         errors++;
      end
   end

   initial begin
      int                    wait_cnt;
      int                    counts[3];
      logic [DATA_WIDTH-1:0] x;
      alu_op_t               o;
      rst_n    = 1'b0;
      in_valid = 1'b0;
      op       = OP_ADD;
      a        = '0;
      b        = '0;
      counts   = '{0, 1, 31};
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      idle_cycles(4);

      // Adder corners
      send_op(OP_ADD, 32'h7fff_ffff, 32'h1, "add_overflow");
      send_op(OP_ADD, 32'hffff_ffff, 32'h1, "add_carry_zero");
      send_op(OP_ADD, 32'h0000_000f, 32'h1, "add_nibble_carry");
      send_op(OP_ADD, 32'h1234_5678, 32'h9abc_def0, "add_mixed");
      send_op(OP_SUB, 32'h0, 32'h1, "sub_borrow");
      send_op(OP_SUB, 32'h5a5a_5a5a, 32'h5a5a_5a5a, "sub_equal");
      send_op(OP_SUB, 32'h8000_0000, 32'h1, "sub_overflow");
      send_op(OP_SUB, 32'h0000_0010, 32'h1, "sub_nibble_borrow");
      idle_cycles(2);

      for (int i = 0; i < 30; i++) begin
         o = alu_op_t'(OP_AND + i % 3);
         send_op(o, $random(seed), $random(seed), "logic_random");
      end

      for (int k = 0; k < 3; k++) begin
         o = alu_op_t'(OP_SHL + k);
         for (int c = 0; c < 3; c++) begin
            send_op(o, 32'h8000_0001, counts[c], "shift_fixed_count");
            send_op(o, $random(seed), counts[c], "shift_fixed_count");
         end
         send_op(o, $random(seed), 32'd37, "shift_count_wrap");
         for (int i = 0; i < 10; i++) begin
            send_op(o, $random(seed), $random(seed), "shift_random_count");
         end
      end
      for (int i = 0; i < 10; i++) begin
         send_op(OP_SAR, $random(seed) | 32'h8000_0000, $random(seed), "sar_negative");
      end

      for (int k = 0; k < 2; k++) begin
         o = k ? OP_MAXU : OP_MINU;
         x = $random(seed);
         send_op(o, x, x, "minmax_equal");
         send_op(o, x, x ^ 32'h5a00_0000, "minmax_top_byte");
         send_op(o, x, x ^ 32'h0000_00a5, "minmax_low_byte");
         for (int i = 0; i < 10; i++) begin
            send_op(o, $random(seed), $random(seed), "minmax_random");
         end
      end

      // Back-to-back stream with random gaps
      for (int i = 0; i < 400; i++) begin
         send_op(random_op(), $random(seed), $random(seed), "stream");
         if ($unsigned($random(seed)) % 5 == 0) begin
            idle_cycles(1 + $unsigned($random(seed)) % 3);
         end
      end
      idle_cycles(1);

      wait_cnt = 0;
      while (exp_q.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
         @(posedge clk);
         wait_cnt++;
      end
      if (exp_q.size() != 0) begin
         $display("Timeout: %0d operations never produced an output", exp_q.size());
         errors++;
      end
      idle_cycles(4);

      $display("%0d operations checked, %0d errors", checked, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- project.f
+incdir+verification
verilog/exec_pkg.sv
verilog/cla_adder.sv
verilog/barrel_shifter.sv
verilog/mag_comp.sv
verilog/flag_gen.sv
verilog/exec_unit.sv
verification/exec_unit_tb.sv

//--- Bender.yml
package:
  name: exec_unit

sources:
  - files:
      - verilog/exec_pkg.sv
      - verilog/cla_adder.sv
      - verilog/barrel_shifter.sv
      - verilog/mag_comp.sv
      - verilog/flag_gen.sv
      - verilog/exec_unit.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/exec_unit_tb.sv
